// File: all.f
hw/cdbPkg.sv
hw/cdbArbiter.sv
hw/aluUnit.sv
hw/branchUnit.sv
hw/robTracker.sv
hw/execCluster.sv
tb/tbExecCluster.sv

// File: hw/aluUnit.sv
// Issue only while available is high; the result waits in one holding register until the bus takes it
`timescale 1ns/100ps

module aluUnit import cdbPkg::*; #(
  parameter int DATA_W = 32,
  parameter int TAG_W  = 3
) (
  input  logic   clk,
  input  logic   rstN,
  input  logic   issue,
  input  aluOpT  op,
  input  dataT   srcA,
  input  dataT   srcB,
  input  robTagT tag,
  input  logic   available,
  output logic   req,
  output dataT   result,
  output robTagT resTag
);

  localparam int SHAMT_W = $clog2(DATA_W);

  logic [DATA_W-1:0] aluOut;
  logic [DATA_W-1:0] resultQ; // Holding register
  logic [TAG_W-1:0]  tagQ;

  // Single-cycle datapath
  always_comb begin
    case (op)
      ALU_ADD: aluOut = srcA + srcB;
      ALU_SUB: aluOut = srcA - srcB;
      ALU_AND: aluOut = srcA & srcB;
      ALU_OR:  aluOut = srcA | srcB;
      ALU_XOR: aluOut = srcA ^ srcB;
      ALU_SLL: aluOut = srcA << srcB[SHAMT_W-1:0];
      ALU_SLT: aluOut = DATA_W'($signed(srcA) < $signed(srcB));
      default: aluOut = '0;
    endcase
  end

  // Request stays up until granted, a new issue refills it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      req <= 1'b0;
    end else if (issue) begin
      req <= 1'b1;
    end else if (req && available) begin
      req <= 1'b0; // Granted this cycle
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      resultQ <= aluOut;
      tagQ    <= tag;
    end
  end

  assign result = resultQ;
  assign resTag = tagQ;

endmodule

// File: hw/branchUnit.sv
// Resolves one branch at a time; no flush or redirect here, the outcome only travels on the bus
`timescale 1ns/100ps

module branchUnit import cdbPkg::*; #(
  parameter int DATA_W = 32,
  parameter int TAG_W  = 3
) (
  input  logic   clk,
  input  logic   rstN,
  input  logic   issue,
  input  brOpT   op,
  input  dataT   srcA,
  input  dataT   srcB,
  input  dataT   pc,
  input  dataT   offset,
  input  logic   predTaken,
  input  robTagT tag,
  input  logic   available,
  output logic   req,
  output dataT   result,
  output robTagT resTag,
  output ctrlT   ctrl,
  output dataT   target
);

  logic              taken;
  logic [DATA_W-1:0] linkPc;   // pc + 4
  logic [DATA_W-1:0] nextPc;
  ctrlT              ctrlNext;
  logic [DATA_W-1:0] linkQ;
  logic [DATA_W-1:0] targetQ;
  logic [TAG_W-1:0]  tagQ;

  // Compare
  always_comb begin
    case (op)
      BR_BEQ:  taken = (srcA == srcB);
      BR_BNE:  taken = (srcA != srcB);
      BR_BLT:  taken = ($signed(srcA) <  $signed(srcB));
      BR_BGE:  taken = ($signed(srcA) >= $signed(srcB));
      default: taken = 1'b0;
    endcase
  end

  assign linkPc = pc + DATA_W'(4);
  assign nextPc = taken ? (pc + offset) : linkPc;

  // Control word packing
  always_comb begin
    ctrlNext = '0;
    ctrlNext[CTRL_OP_LSB +: $bits(brOpT)] = op;
    ctrlNext[CTRL_TAKEN]   = taken;
    ctrlNext[CTRL_MISPRED] = taken ^ predTaken; // Wrong guess
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      req <= 1'b0;
    end else if (issue) begin
      req <= 1'b1;
    end else if (req && available) begin
      req <= 1'b0;
    end
  end

  // Held until granted
  always_ff @(posedge clk) begin
    if (issue) begin
      linkQ   <= linkPc;
      targetQ <= nextPc;
      tagQ    <= tag;
      ctrl    <= ctrlNext;
    end
  end

  assign result = linkQ;
  assign target = targetQ;
  assign resTag = tagQ;

endmodule

// File: hw/cdbArbiter.sv
// Two requesters only; a unit may keep requesting only while available is low, and cdbTarget holds its last branch value
`timescale 1ns/100ps

module cdbArbiter import cdbPkg::*; #(
  parameter int DATA_W = 32,
  parameter int TAG_W  = 3
) (
  input  logic   clk,
  input  logic   rstN,
  input  logic   aluReq,
  input  dataT   aluResult,
  input  robTagT aluTag,
  input  logic   brReq,
  input  dataT   brResult,
  input  robTagT brTag,
  input  ctrlT   brCtrl,
  input  dataT   brTarget,
  output logic   aluAvailable,
  output logic   brAvailable,
  output logic   cdbValid,
  output dataT   cdbResult,
  output robTagT cdbTag,
  output logic   cdbIsControl,
  output ctrlT   cdbCtrl,
  output dataT   cdbTarget
);

  grantT grant;
  logic  favorBr;               // Priority pointer, 0 favors the ALU
  logic  [DATA_W-1:0] selResult; // Winner's result
  logic  [TAG_W-1:0]  selTag;    // Winner's tag

  // Pick one requester; the pointer only matters on a conflict
  always_comb begin
    grant = GNT_NONE;
    if (aluReq && (!brReq || !favorBr)) begin
      grant = GNT_ALU;
    end else if (brReq) begin
      grant = GNT_BR;
    end
  end

  // Result and tag mux
  always_comb begin
    selResult = '0;
    selTag    = '0;
    case (grant)
      GNT_ALU: begin
        selResult = aluResult;
        selTag    = aluTag;
      end
      GNT_BR: begin
        selResult = brResult;
        selTag    = brTag;
      end
      default: ;
    endcase
  end

  // Unit may take new work when idle or when its result leaves this cycle
  assign aluAvailable = (grant == GNT_ALU) || !aluReq;
  assign brAvailable  = (grant == GNT_BR)  || !brReq;

  // Registered broadcast
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      favorBr      <= 1'b0;
      cdbValid     <= 1'b0;
      cdbResult    <= '0;
      cdbTag       <= '0;
      cdbIsControl <= 1'b0;
      cdbCtrl      <= '0;
      cdbTarget    <= '0;
    end else begin
      cdbValid <= (grant != GNT_NONE); // One cycle per grant
      if (grant != GNT_NONE) begin
        cdbResult    <= selResult;
        cdbTag       <= selTag;
        cdbIsControl <= (grant == GNT_BR);
        cdbCtrl      <= (grant == GNT_BR) ? brCtrl : '0; // ALU carries no control word
        favorBr      <= (grant == GNT_ALU); // Turn goes to the loser
      end
      if (grant == GNT_BR) begin
        cdbTarget <= brTarget; // Kept otherwise
      end
    end
  end

endmodule

// File: hw/cdbPkg.sv
// Shared widths and encodings for the writeback cluster; the typedef widths must match DATA_W and TAG_W at the top level
package cdbPkg;

  // Widths that carry a meaning
  typedef logic [31:0] dataT;   // Operand, result and address word
  typedef logic [2:0]  robTagT; // Reorder tag, eight entries
  typedef logic [6:0]  ctrlT;   // Branch control word

  // Control word layout
  localparam int CTRL_MISPRED = 0; // Taken differs from prediction
  localparam int CTRL_TAKEN   = 1; // Branch resolved taken
  localparam int CTRL_OP_LSB  = 2; // Branch opcode sits in bits 6..2

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5, // Shift by low bits of srcB
    ALU_SLT = 3'd6  // Signed compare, result is 0 or 1
  } aluOpT;

  // Branch operations, sized to fill the opcode field of the control word
  typedef enum logic [4:0] {
    BR_BEQ = 5'd0,
    BR_BNE = 5'd1,
    BR_BLT = 5'd2, // Signed
    BR_BGE = 5'd3  // Signed
  } brOpT;

  // Bus grant
  typedef enum logic [1:0] {
    GNT_NONE = 2'd0,
    GNT_ALU  = 2'd1,
    GNT_BR   = 2'd2
  } grantT;

endpackage

// File: hw/execCluster.sv
// Issuer must obey aluAvailable and brAvailable and allocate tags in program order; no flush path
`timescale 1ns/100ps

module execCluster import cdbPkg::*; #(
  parameter int DATA_W = 32,
  parameter int TAG_W  = 3
) (
  input  logic   clk,
  input  logic   rstN,
  // ALU issue
  input  logic   aluIssue,
  input  aluOpT  aluOp,
  input  dataT   aluSrcA,
  input  dataT   aluSrcB,
  input  robTagT aluTag,
  // Branch issue
  input  logic   brIssue,
  input  brOpT   brOp,
  input  dataT   brSrcA,
  input  dataT   brSrcB,
  input  dataT   brPc,
  input  dataT   brOffset,
  input  logic   brPredTaken,
  input  robTagT brTag,
  // Tag allocation
  input  logic   allocReq,
  output robTagT allocTag,
  output logic   full,
  output logic   aluAvailable,
  output logic   brAvailable,
  // Common data bus
  output logic   cdbValid,
  output dataT   cdbResult,
  output robTagT cdbTag,
  output logic   cdbIsControl,
  output ctrlT   cdbCtrl,
  output dataT   cdbTarget,
  // Retirement
  output logic   retireValid,
  output robTagT retireTag,
  output dataT   retireResult,
  output logic   retireIsControl,
  output ctrlT   retireCtrl,
  output dataT   retireTarget
);

  logic   aluReq, brReq;
  dataT   aluResult, brResult, brTarget;
  robTagT aluResTag, brResTag;
  ctrlT   brCtrl;

  aluUnit #(.DATA_W(DATA_W), .TAG_W(TAG_W)) i_aluUnit (
    .clk(clk), .rstN(rstN), .issue(aluIssue), .op(aluOp), .srcA(aluSrcA), .srcB(aluSrcB),
    .tag(aluTag), .available(aluAvailable), .req(aluReq), .result(aluResult),
    .resTag(aluResTag)
  );

  branchUnit #(.DATA_W(DATA_W), .TAG_W(TAG_W)) i_branchUnit (
    .clk(clk), .rstN(rstN), .issue(brIssue), .op(brOp), .srcA(brSrcA), .srcB(brSrcB),
    .pc(brPc), .offset(brOffset), .predTaken(brPredTaken), .tag(brTag),
    .available(brAvailable), .req(brReq), .result(brResult), .resTag(brResTag),
    .ctrl(brCtrl), .target(brTarget)
  );

  cdbArbiter #(.DATA_W(DATA_W), .TAG_W(TAG_W)) i_cdbArbiter (
    .clk(clk), .rstN(rstN), .aluReq(aluReq), .aluResult(aluResult), .aluTag(aluResTag),
    .brReq(brReq), .brResult(brResult), .brTag(brResTag), .brCtrl(brCtrl),
    .brTarget(brTarget), .aluAvailable(aluAvailable), .brAvailable(brAvailable),
    .cdbValid(cdbValid), .cdbResult(cdbResult), .cdbTag(cdbTag),
    .cdbIsControl(cdbIsControl), .cdbCtrl(cdbCtrl), .cdbTarget(cdbTarget)
  );

  robTracker #(.DATA_W(DATA_W), .TAG_W(TAG_W)) i_robTracker (
    .clk(clk), .rstN(rstN), .allocReq(allocReq), .cdbValid(cdbValid),
    .cdbResult(cdbResult), .cdbTag(cdbTag), .cdbIsControl(cdbIsControl),
    .cdbCtrl(cdbCtrl), .cdbTarget(cdbTarget), .allocTag(allocTag), .full(full),
    .retireValid(retireValid), .retireTag(retireTag), .retireResult(retireResult),
    .retireIsControl(retireIsControl), .retireCtrl(retireCtrl),
    .retireTarget(retireTarget)
  );

endmodule

// File: hw/robTracker.sv
// Depth is 2**TAG_W; allocReq while full and broadcasts to unallocated tags are not guarded
`timescale 1ns/100ps

module robTracker import cdbPkg::*; #(
  parameter int DATA_W = 32,
  parameter int TAG_W  = 3
) (
  input  logic   clk,
  input  logic   rstN,
  input  logic   allocReq,
  input  logic   cdbValid,
  input  dataT   cdbResult,
  input  robTagT cdbTag,
  input  logic   cdbIsControl,
  input  ctrlT   cdbCtrl,
  input  dataT   cdbTarget,
  output robTagT allocTag,
  output logic   full,
  output logic   retireValid,
  output robTagT retireTag,
  output dataT   retireResult,
  output logic   retireIsControl,
  output ctrlT   retireCtrl,
  output dataT   retireTarget
);

  localparam int DEPTH = 1 << TAG_W;

  logic [TAG_W-1:0]  head, tail;
  logic [TAG_W:0]    count;        // One extra bit for full
  logic [DEPTH-1:0]  doneQ;
  logic [DATA_W-1:0] resultMem [DEPTH];
  logic [DATA_W-1:0] targetMem [DEPTH];
  ctrlT              ctrlMem   [DEPTH];
  logic              isCtrlMem [DEPTH];
  logic              bypass;       // Bus writes the head this cycle
  logic              retireNow;
  logic              allocNow;

  assign allocTag  = tail;
  assign full      = (count == (TAG_W+1)'(DEPTH));
  assign allocNow  = allocReq && !full;
  assign bypass    = cdbValid && (cdbTag == head) && (count != '0);
  assign retireNow = (count != '0) && (doneQ[head] || bypass);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      doneQ       <= '0;
      retireValid <= 1'b0;
    end else begin
      retireValid <= retireNow;
      if (allocNow) tail <= tail + 1'b1;
      if (retireNow) head <= head + 1'b1;
      count <= count + (TAG_W+1)'(allocNow) - (TAG_W+1)'(retireNow);
      if (cdbValid) doneQ[cdbTag] <= 1'b1;
      if (retireNow) doneQ[head] <= 1'b0; // Wins over a same-cycle bus write
    end
  end

  // Payload capture, out of order
  always_ff @(posedge clk) begin
    if (cdbValid) begin
      resultMem[cdbTag] <= cdbResult;
      targetMem[cdbTag] <= cdbTarget;
      ctrlMem[cdbTag]   <= cdbCtrl;
      isCtrlMem[cdbTag] <= cdbIsControl;
    end
  end

  // Retire payload, straight from the bus when it targets the head
  always_ff @(posedge clk) begin
    if (retireNow) begin
      retireTag       <= head;
      retireResult    <= bypass ? cdbResult    : resultMem[head];
      retireTarget    <= bypass ? cdbTarget    : targetMem[head];
      retireCtrl      <= bypass ? cdbCtrl      : ctrlMem[head];
      retireIsControl <= bypass ? cdbIsControl : isCtrlMem[head];
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the execution cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -j 0 --top-module tbExecCluster -Mdir "$BUILD_DIR" -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/VtbExecCluster" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: tb/tbExecCluster.sv
// Issue follows a model of the grant rule, so a unit may refill in its grant cycle; tags are reused only after the tracker drains
`timescale 1ns/100ps

module tbExecCluster import cdbPkg::*; ();

  localparam int DATA_W         = 32;
  localparam int TAG_W          = 3;
  localparam int DEPTH          = 8;
  localparam int NUM_OPS        = 48;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 20; // 20 cycles per operation

  logic   clk, rstN;
  logic   aluIssue, brIssue, brPredTaken, allocReq;
  aluOpT  aluOp;
  brOpT   brOp;
  dataT   aluSrcA, aluSrcB, brSrcA, brSrcB, brPc, brOffset;
  robTagT aluTag, brTag, allocTag, cdbTag, retireTag;
  logic   full, aluAvailable, brAvailable, cdbValid, cdbIsControl;
  logic   retireValid, retireIsControl;
  dataT   cdbResult, cdbTarget, retireResult, retireTarget;
  ctrlT   cdbCtrl, retireCtrl;

  // Reference model state
  logic [31:0] seed;
  int          errCount, allocSeen, retiredCount, modelCount, driverTail;
  logic        lastGrantBr;               // 1 when the branch unit won last
  logic        expectWin, expectWinBr;    // Conflict seen, winner due on the bus
  robTagT      order[$];                  // Program order of allocation
  robTagT      toIssue[$];
  logic        issued[DEPTH];
  logic        bcSeen[DEPTH];
  dataT        expResult[DEPTH], expTarget[DEPTH], bcResult[DEPTH], bcTarget[DEPTH];
  logic        expIsCtrl[DEPTH], bcIsCtrl[DEPTH];
  ctrlT        expCtrl[DEPTH], bcCtrl[DEPTH];

  execCluster #(.DATA_W(DATA_W), .TAG_W(TAG_W)) i_execCluster (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRand();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Opcode rules for the ALU
  function automatic dataT aluRef(input aluOpT op, input dataT a, input dataT b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SLT: return dataT'($signed(a) < $signed(b)); // Signed, 0 or 1
      default: return '0;
    endcase
  endfunction

  function automatic logic takenRef(input brOpT op, input dataT a, input dataT b);
    case (op)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return $signed(a) < $signed(b);
      BR_BGE:  return $signed(a) >= $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    errCount++;
    $display("ERR %s got %h expected %h", name, got, exp);
  endtask

  task automatic reportFailure(input string msg);
    errCount++;
    $display("%s", msg);
  endtask

  // Hand out k tags in program order, no issue yet
  task automatic allocate(input int k);
    for (int i = 0; i < k; i++) begin
      @(posedge clk);
      allocReq <= 1'b1;
      order.push_back(robTagT'(driverTail));
      toIssue.push_back(robTagT'(driverTail));
      driverTail++;
    end
    @(posedge clk);
    allocReq <= 1'b0;
  endtask

  task automatic driveAlu(input robTagT t);
    aluOpT op;
    dataT  a, b;
    op = aluOpT'(3'(nextRand() % 7));
    a  = nextRand();
    b  = nextRand();
    aluOp     <= op;
    aluSrcA   <= a;
    aluSrcB   <= b;
    aluTag    <= t;
    aluIssue  <= 1'b1;
    expResult[t] = aluRef(op, a, b);
    expIsCtrl[t] = 1'b0;
    issued[t]    = 1'b1;
    bcSeen[t]    = 1'b0;
  endtask

  task automatic driveBr(input robTagT t);
    brOpT        op;
    dataT        a, b, pc, off;
    logic [31:0] r;
    logic        tk;
    ctrlT        c;
    op  = brOpT'(5'(nextRand() % 4));
    a   = nextRand();
    b   = (nextRand() % 3 == 0) ? a : nextRand(); // Equal operands now and then
    pc  = nextRand() & 32'hffff_fffc;
    r   = nextRand();
    off = {{19{r[12]}}, r[12:1], 1'b0};           // Signed halfword offset
    tk  = takenRef(op, a, b);
    c   = '0;
    c[6:2]         = op;
    c[CTRL_TAKEN]   = tk;
    c[CTRL_MISPRED] = tk ^ r[20];
    brOp        <= op;
    brSrcA      <= a;
    brSrcB      <= b;
    brPc        <= pc;
    brOffset    <= off;
    brPredTaken <= r[20];
    brTag       <= t;
    brIssue     <= 1'b1;
    expResult[t] = pc + 32'd4;                   // Link value
    expTarget[t] = tk ? pc + off : pc + 32'd4;
    expCtrl[t]   = c;
    expIsCtrl[t] = 1'b1;
    issued[t]    = 1'b1;
    bcSeen[t]    = 1'b0;
  endtask

  // Random order over the allocated tags, random unit per tag
  task automatic issueAll();
    int          idx;
    logic [31:0] r;
    logic        canAlu, canBr;
    logic        aluBusy, brBusy; // Unit requests expected in the coming cycle
    logic        favorBr;         // Priority pointer as the grant rule predicts it
    aluBusy = 1'b0; // Both units idle after the previous drain
    brBusy  = 1'b0;
    favorBr = !lastGrantBr;
    while (toIssue.size() > 0) begin
      @(posedge clk);
      if (aluBusy && aluAvailable) begin
        favorBr = 1'b1; // ALU won last cycle
      end else if (brBusy && brAvailable) begin
        favorBr = 1'b0;
      end
      aluBusy = aluIssue || (aluBusy && !aluAvailable);
      brBusy  = brIssue || (brBusy && !brAvailable);
      canAlu  = !aluBusy || !brBusy || !favorBr; // Idle or granted, refill allowed
      canBr   = !brBusy || !aluBusy || favorBr;
      aluIssue <= 1'b0;
      brIssue  <= 1'b0;
      r = nextRand();
      if (canAlu && r[3] && toIssue.size() > 0) begin
        idx = int'(nextRand() % toIssue.size());
        driveAlu(toIssue[idx]);
        toIssue.delete(idx);
      end
      if (canBr && r[7] && toIssue.size() > 0) begin
        idx = int'(nextRand() % toIssue.size());
        driveBr(toIssue[idx]);
        toIssue.delete(idx);
      end
    end
    @(posedge clk);
    aluIssue <= 1'b0;
    brIssue  <= 1'b0;
  endtask

  // Never both units held off in one cycle
  assert property (@(posedge clk) disable iff (!rstN) aluAvailable || brAvailable)
    else reportFailure("Both units were held off the bus in the same cycle");

  always @(posedge clk) begin
    robTagT expTag;
    if (rstN) begin
      if (allocReq) begin
        assert (allocTag == robTagT'(allocSeen))
          else reportMismatch("allocTag", 32'(allocTag), 32'(allocSeen % DEPTH));
        allocSeen++;
      end
      modelCount = modelCount - int'(retireValid); // Retire took effect one edge earlier
      assert (full == (modelCount == DEPTH))
        else reportMismatch("full", 32'(full), 32'(modelCount == DEPTH));
      modelCount = modelCount + int'(allocReq);

      // Issue strobes only in cycles where the unit is free
      assert (!aluIssue || aluAvailable)
        else reportMismatch("aluAvailable", 32'(aluAvailable), 32'h1);
      assert (!brIssue || brAvailable)
        else reportMismatch("brAvailable", 32'(brAvailable), 32'h1);

      if (expectWin) begin
        assert (cdbValid)
          else reportFailure("Conflict winner did not reach the bus in the next cycle");
        assert (!cdbValid || cdbIsControl == expectWinBr)
          else reportMismatch("cdbIsControl", 32'(cdbIsControl), 32'(expectWinBr));
      end

      if (cdbValid) begin
        if (!issued[cdbTag] || bcSeen[cdbTag]) begin
          reportFailure($sformatf("Broadcast for tag %0d that is not outstanding", cdbTag));
        end else begin
          assert (cdbResult == expResult[cdbTag])
            else reportMismatch("cdbResult", cdbResult, expResult[cdbTag]);
          assert (cdbIsControl == expIsCtrl[cdbTag])
            else reportMismatch("cdbIsControl", 32'(cdbIsControl), 32'(expIsCtrl[cdbTag]));
          if (expIsCtrl[cdbTag]) begin
            assert (cdbCtrl == expCtrl[cdbTag])
              else reportMismatch("cdbCtrl", 32'(cdbCtrl), 32'(expCtrl[cdbTag]));
            assert (cdbTarget == expTarget[cdbTag])
              else reportMismatch("cdbTarget", cdbTarget, expTarget[cdbTag]);
          end
        end
        bcSeen[cdbTag]   = 1'b1;
        bcResult[cdbTag] = cdbResult;   // Kept for the retire compare
        bcTarget[cdbTag] = cdbTarget;
        bcCtrl[cdbTag]   = cdbCtrl;
        bcIsCtrl[cdbTag] = cdbIsControl;
        lastGrantBr      = cdbIsControl;
      end

      // A held-off unit means a conflict this cycle
      expectWin = 1'b0;
      if (!aluAvailable || !brAvailable) begin
        expectWin   = 1'b1;
        expectWinBr = !aluAvailable;
        assert (expectWinBr != lastGrantBr)
          else reportFailure("Arbiter granted the unit that also won the previous grant");
      end

      if (retireValid) begin
        if (order.size() == 0) begin
          reportFailure("Retirement with no allocated entry");
        end else begin
          expTag = order.pop_front();
          assert (retireTag == expTag)
            else reportMismatch("retireTag", 32'(retireTag), 32'(expTag));
          assert (bcSeen[retireTag])
            else reportFailure($sformatf("Tag %0d retired before its broadcast", retireTag));
          assert (retireResult == bcResult[retireTag])
            else reportMismatch("retireResult", retireResult, bcResult[retireTag]);
          assert (retireIsControl == bcIsCtrl[retireTag])
            else reportMismatch("retireIsControl", 32'(retireIsControl),
                                32'(bcIsCtrl[retireTag]));
          assert (retireCtrl == bcCtrl[retireTag])
            else reportMismatch("retireCtrl", 32'(retireCtrl), 32'(bcCtrl[retireTag]));
          assert (retireTarget == bcTarget[retireTag])
            else reportMismatch("retireTarget", retireTarget, bcTarget[retireTag]);
          issued[retireTag] = 1'b0;
        end
        retiredCount++;
      end
    end
  end

  initial begin
    int k;
    int opsDone;
    seed         = 32'h0bea8ec6;
    errCount     = 0;
    allocSeen    = 0;
    retiredCount = 0;
    modelCount   = 0;
    driverTail   = 0;
    lastGrantBr  = 1'b1; // Pointer favors the ALU out of reset
    expectWin    = 1'b0;
    expectWinBr  = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      issued[i] = 1'b0;
      bcSeen[i] = 1'b0;
    end
    rstN        = 1'b0;
    aluIssue    = 1'b0;
    aluOp       = ALU_ADD;
    aluSrcA     = '0;
    aluSrcB     = '0;
    aluTag      = '0;
    brIssue     = 1'b0;
    brOp        = BR_BEQ;
    brSrcA      = '0;
    brSrcB      = '0;
    brPc        = '0;
    brOffset    = '0;
    brPredTaken = 1'b0;
    brTag       = '0;
    allocReq    = 1'b0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    // Idle state right after reset
    assert (!cdbValid) else reportMismatch("cdbValid", 32'(cdbValid), 32'h0);
    assert (!retireValid) else reportMismatch("retireValid", 32'(retireValid), 32'h0);
    assert (!full) else reportMismatch("full", 32'(full), 32'h0);
    assert (aluAvailable) else reportMismatch("aluAvailable", 32'(aluAvailable), 32'h1);
    assert (brAvailable) else reportMismatch("brAvailable", 32'(brAvailable), 32'h1);

    opsDone = 0;
    k       = DEPTH; // First round fills the tracker
    while (opsDone < NUM_OPS) begin
      allocate(k);
      issueAll();
      while (retiredCount < opsDone + k) @(posedge clk); // Drain, watchdog bounds it
      opsDone = opsDone + k;
      k = 1 + int'(nextRand() % DEPTH);
      if (k > NUM_OPS - opsDone) k = NUM_OPS - opsDone;
    end
    repeat (2) @(posedge clk);
    assert (order.size() == 0)
      else reportFailure("Allocated entries never retired");
    $display("Error count: %0d", errCount);
    if (errCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES + 10) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d operations retired, error count %0d",
             TIMEOUT_CYCLES, retiredCount, NUM_OPS, errCount);
    $display("Finished with errors");
    $finish;
  end

endmodule
